/* rtl/conway_pkg.sv */
// Game of Life package: mode encoding, default grid size, cell index rule
`default_nettype none

package conway_pkg;

    // Level-controlled mode input, sampled every clock
    typedef enum logic [1:0] {
        mode_load   = 2'b00,  // Shift cells in, memory follows the input register
        mode_run    = 2'b01,  // One generation per clock
        mode_output = 2'b10,  // Shift the field out, top bit first
        mode_hold   = 2'b11   // Freeze all registers
    } mode_t;

    // Default grid size, used as top level parameter defaults
    localparam int grid_width_default  = 8;
    localparam int grid_height_default = 8;

    // The field is one flat vector of grid_width * grid_height bits.
    // Cell (row, col) sits at bit row * grid_width + col,
    // so row 0 col 0 is bit 0 and the last row holds the top bits.
    // Serial streams move the top bit first, in and out alike.

endpackage

`default_nettype wire

/* rtl/serial_to_parallel.sv */
// Input shift register assembling the serial cell stream into a field
`timescale 1ns/1ps
`default_nettype none

module serial_to_parallel #(
    parameter int grid_width  = conway_pkg::grid_width_default,   // Cells per row
    parameter int grid_height = conway_pkg::grid_height_default   // Rows in the grid
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              en,          // Load mode
    input  logic                              data_in,     // One cell per clock
    output logic [grid_width*grid_height-1:0] field,       // Assembled field so far
    output logic [grid_width*grid_height-1:0] field_next   // Value field takes next edge
);

    localparam int field_size = grid_width * grid_height;

    // New bit enters at bit 0, oldest bit drifts toward the top
    // After field_size shifts the first bit lands on the top bit
    assign field_next = {field[field_size-2:0], data_in};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            field <= '0;            // Empty field
        end else if (en) begin
            field <= field_next;    // Shift one cell in
        end
    end

endmodule

`default_nettype wire

/* rtl/life_cell.sv */
// Single cell rule: neighbour count with birth on three, survival on two or three
`timescale 1ns/1ps
`default_nettype none

module life_cell (
    input  logic       alive,        // Current state of this cell
    input  logic [7:0] neighbours,   // Eight surrounding cells, dead if off grid
    output logic       next_alive    // State for the next generation
);

    logic [3:0] live_count;  // 0 to 8 fits in four bits

    // Population count of the neighbourhood
    always_comb begin
        live_count = '0;
        for (int k = 0; k < 8; k++) begin
            live_count = live_count + {3'b000, neighbours[k]};
        end
    end

    // Conway rule B3/S23
    always_comb begin
        if (live_count == 4'd3) begin
            next_alive = 1'b1;              // Birth or survival on three
        end else if (live_count == 4'd2) begin
            next_alive = alive;             // Two only keeps a live cell alive
        end else begin
            next_alive = 1'b0;              // Loneliness or overcrowding
        end
    end

endmodule

`default_nettype wire

/* rtl/cell_grid.sv */
// Combinational next-generation grid of life_cell instances with dead edges
`timescale 1ns/1ps
`default_nettype none

module cell_grid #(
    parameter int grid_width  = conway_pkg::grid_width_default,   // Cells per row
    parameter int grid_height = conway_pkg::grid_height_default   // Rows in the grid
) (
    input  logic [grid_width*grid_height-1:0] state,       // Current generation
    output logic [grid_width*grid_height-1:0] next_state   // Next generation
);

    // Neighbour offsets, slot k of the neighbours vector
    // Slots 0..2 row above, 3..4 same row, 5..7 row below
    localparam int row_ofs [8] = '{-1, -1, -1,  0, 0,  1, 1, 1};
    localparam int col_ofs [8] = '{-1,  0,  1, -1, 1, -1, 0, 1};

    for (genvar r = 0; r < grid_height; r++) begin : g_row
        for (genvar c = 0; c < grid_width; c++) begin : g_col

            logic [7:0] nbr;  // Gathered neighbours of cell (r, c)

            for (genvar k = 0; k < 8; k++) begin : g_nbr
                localparam int nr = r + row_ofs[k];
                localparam int nc = c + col_ofs[k];

                // No wraparound, anything past an edge is dead
                if (nr >= 0 && nr < grid_height && nc >= 0 && nc < grid_width) begin : g_in
                    assign nbr[k] = state[nr*grid_width + nc];
                end else begin : g_out
                    assign nbr[k] = 1'b0;
                end
            end

            life_cell u_cell (
                .alive      (state[r*grid_width + c]),
                .neighbours (nbr),
                .next_alive (next_state[r*grid_width + c])
            );

        end
    end

endmodule

`default_nettype wire

/* rtl/system_memory.sv */
// Generation register selecting the loaded field or the computed next generation
`timescale 1ns/1ps
`default_nettype none

module system_memory #(
    parameter int grid_width  = conway_pkg::grid_width_default,   // Cells per row
    parameter int grid_height = conway_pkg::grid_height_default   // Rows in the grid
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              load_en,     // Follow the input register
    input  logic                              run_en,      // Advance one generation
    input  logic [grid_width*grid_height-1:0] load_field,  // From serial_to_parallel
    input  logic [grid_width*grid_height-1:0] grid_field,  // From cell_grid
    output logic [grid_width*grid_height-1:0] state        // Stored generation
);

    // Only one of the two enables is high at a time, load checked first anyway
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= '0;                // Dead field after reset
        end else if (load_en) begin
            state <= load_field;        // Track the field being shifted in
        end else if (run_en) begin
            state <= grid_field;        // Store next generation
        end
        // Output and hold keep the stored generation
    end

endmodule

`default_nettype wire

/* rtl/parallel_to_serial.sv */
// Output shift register mirroring memory, shifting out top bit first
`timescale 1ns/1ps
`default_nettype none

module parallel_to_serial #(
    parameter int grid_width  = conway_pkg::grid_width_default,   // Cells per row
    parameter int grid_height = conway_pkg::grid_height_default   // Rows in the grid
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              capture_en,  // Copy field_in
    input  logic                              shift_en,    // Move one cell out
    input  logic [grid_width*grid_height-1:0] field_in,    // Value memory takes this edge
    output logic                              data_out     // Serial cell stream
);

    localparam int field_size = grid_width * grid_height;

    logic [field_size-1:0] shreg;  // Field waiting to leave

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shreg <= '0;
        end else if (capture_en) begin
            shreg <= field_in;                          // Stay in step with memory
        end else if (shift_en) begin
            shreg <= {shreg[field_size-2:0], 1'b0};     // Next cell to the top, zero fill
        end
        // Hold keeps the position within a stream
    end

    // Top bit visible straight away, no extra register stage
    assign data_out = shreg[field_size-1];

endmodule

`default_nettype wire

/* rtl/conway_8x8_serial.sv */
// Top level Game of Life engine: mode decode, input, grid, memory and output blocks
`timescale 1ns/1ps
`default_nettype none

module conway_8x8_serial #(
    parameter int grid_width  = conway_pkg::grid_width_default,   // Cells per row
    parameter int grid_height = conway_pkg::grid_height_default   // Rows in the grid
) (
    input  logic              clk,       // System clock
    input  logic              rst_n,     // Synchronous reset, active low
    input  conway_pkg::mode_t mode,      // Load, run, output or hold
    input  logic              data_in,   // Serial cells in
    output logic              data_out   // Serial cells out
);

    import conway_pkg::*;

    localparam int field_size = grid_width * grid_height;

    logic                  load_en;        // mode_load
    logic                  run_en;         // mode_run
    logic                  output_en;      // mode_output
    logic                  capture_en;     // Output register follows memory
    logic [field_size-1:0] load_next;      // Input register after this edge
    logic [field_size-1:0] mem_state;      // Stored generation
    logic [field_size-1:0] next_state;     // Generation after mem_state
    logic [field_size-1:0] capture_field;  // What memory stores this edge

    // One-hot mode decode, hold raises no enable
    always_comb begin
        load_en   = 1'b0;
        run_en    = 1'b0;
        output_en = 1'b0;
        case (mode)
            mode_load:   load_en   = 1'b1;
            mode_run:    run_en    = 1'b1;
            mode_output: output_en = 1'b1;
            default:     ;                  // mode_hold
        endcase
    end

    assign capture_en = load_en | run_en;

    // Same selection as the memory, so both registers agree after load or run
    assign capture_field = load_en ? load_next : next_state;

    serial_to_parallel #(
        .grid_width  (grid_width),
        .grid_height (grid_height)
    ) u_input_shift (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (load_en),
        .data_in    (data_in),
        .field      (),             // Only the next value is needed here
        .field_next (load_next)
    );

    cell_grid #(
        .grid_width  (grid_width),
        .grid_height (grid_height)
    ) u_grid (
        .state      (mem_state),
        .next_state (next_state)
    );

    system_memory #(
        .grid_width  (grid_width),
        .grid_height (grid_height)
    ) u_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_en    (load_en),
        .run_en     (run_en),
        .load_field (load_next),    // Complete field on the last load edge
        .grid_field (next_state),
        .state      (mem_state)
    );

    parallel_to_serial #(
        .grid_width  (grid_width),
        .grid_height (grid_height)
    ) u_output_shift (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture_en (capture_en),
        .shift_en   (output_en),
        .field_in   (capture_field),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

/* bench/tb_conway.sv */
// Testbench with clock, reset, life reference model, check task, directed tests and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_conway;

    import conway_pkg::*;

    localparam int gw          = grid_width_default;   // Model sized from the package
    localparam int gh          = grid_height_default;
    localparam int fs          = gw * gh;              // Cells per field
    localparam int clk_period  = 10;                   // ns
    localparam int test_cycles = 12000;                // Rough sum over all tests
    localparam int margin_ns   = 5000;

    logic  clk;
    logic  rst_n;
    mode_t mode;
    logic  data_in;
    logic  data_out;

    logic [fs-1:0] model;          // Expected memory contents
    int            seed = 81560;   // Shared by every random draw

    conway_8x8_serial #(
        .grid_width  (gw),
        .grid_height (gh)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .mode     (mode),
        .data_in  (data_in),
        .data_out (data_out)
    );

    // Free running clock
    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Watchdog, ends a run that never reaches its end
    initial begin
        #(test_cycles * clk_period + margin_ns);
        $display("ERROR: simulation timed out at %0t, a test never finished", $time);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    // Compare two fields, stop at the first difference
    task automatic check(input logic [fs-1:0] got, input logic [fs-1:0] expected,
                         input string what);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // Reference generation step, rule B3/S23
    // Neighbours past any edge count as dead
    task automatic life_step(input logic [fs-1:0] cur, output logic [fs-1:0] nxt);
        int cnt;
        int rr;
        int cc;
        nxt = '0;
        for (int r = 0; r < gh; r++) begin
            for (int c = 0; c < gw; c++) begin
                cnt = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        rr = r + dr;
                        cc = c + dc;
                        if ((dr != 0 || dc != 0) &&
                            rr >= 0 && rr < gh && cc >= 0 && cc < gw) begin
                            if (cur[rr*gw + cc]) begin
                                cnt++;
                            end
                        end
                    end
                end
                // Birth on three, survival on two or three
                nxt[r*gw + c] = (cnt == 3) || (cnt == 2 && cur[r*gw + c]);
            end
        end
    endtask

    // Shift a whole field in, first bit ends up on top
    task automatic load_field(input logic [fs-1:0] pattern);
        for (int i = fs - 1; i >= 0; i--) begin
            @(negedge clk);
            mode    = mode_load;
            data_in = pattern[i];           // Top bit first
        end
        model = pattern;                    // Memory follows the last load edge
    endtask

    // N run edges, model advanced alongside
    task automatic run_gens(input int n);
        logic [fs-1:0] nxt;
        for (int g = 0; g < n; g++) begin
            @(negedge clk);
            mode = mode_run;
            life_step(model, nxt);
            model = nxt;
        end
    endtask

    task automatic hold_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            mode = mode_hold;               // Nothing may move
        end
    endtask

    // Stream n cells out into acc, so partial streams can be joined
    task automatic shift_out(input int n, inout logic [fs-1:0] acc);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            acc  = {acc[fs-2:0], data_out}; // Sampled before the shifting edge
            mode = mode_output;
        end
    endtask

    task automatic read_field(output logic [fs-1:0] f);
        logic [fs-1:0] acc;
        acc = '0;
        shift_out(fs, acc);
        f = acc;
    endtask

    // One generation on the DUT, then read back against the model
    task automatic step_and_compare(input string what, output logic [fs-1:0] got);
        run_gens(1);
        read_field(got);
        check(got, model, what);
    endtask

    // Empty field out of reset, and it stays empty
    task automatic test_reset_state();
        logic [fs-1:0] got;
        $display("Reset state");
        read_field(got);
        check(got, '0, "field after reset");
        run_gens(3);
        read_field(got);
        check(got, model, "empty field after three generations");
    endtask

    // Load path and serial order, then memory kept the whole field
    task automatic test_load_readback();
        logic [fs-1:0] patterns [5];
        logic [fs-1:0] got;
        $display("Load and read back");
        patterns[0] = 64'h0123_4567_89ab_cdef;   // Every nibble differs
        patterns[1] = 64'h8000_0000_0000_0001;   // First and last bit only
        patterns[2] = 64'hffff_ffff_ffff_ffff;
        patterns[3] = 64'haaaa_5555_aaaa_5555;
        patterns[4] = {$random(seed), $random(seed)};
        for (int k = 0; k < 5; k++) begin
            load_field(patterns[k]);
            read_field(got);
            check(got, patterns[k], $sformatf("readback of pattern %0d", k));
            step_and_compare($sformatf("one generation from pattern %0d", k), got);
        end
    endtask

    // One byte per row below, row 7 in the top byte, column 0 in bit 0 of a byte
    task automatic test_still_and_blinker();
        logic [fs-1:0] block;
        logic [fs-1:0] blink_h;
        logic [fs-1:0] blink_v;
        logic [fs-1:0] got;
        $display("Still life and oscillator");
        block   = 64'h0000_0018_1800_0000;     // Rows 3 and 4, columns 3 and 4
        blink_h = 64'h0000_001c_0000_0000;     // Row 4, columns 2 to 4
        blink_v = 64'h0000_0808_0800_0000;     // Column 3, rows 3 to 5
        load_field(block);
        for (int g = 0; g < 4; g++) begin
            step_and_compare("block generation", got);
            check(got, block, "block unchanged");
        end
        load_field(blink_h);
        for (int g = 1; g <= 6; g++) begin
            step_and_compare("blinker generation", got);
            if (g % 2 == 0) begin
                check(got, blink_h, "blinker horizontal phase");
            end else begin
                check(got, blink_v, "blinker vertical phase");
            end
        end
    endtask

    // Patterns touching corners and edges, eight generations each
    task automatic test_boundaries();
        logic [fs-1:0] patterns [7];
        logic [fs-1:0] got;
        $display("Boundaries");
        patterns[0] = 64'he080_4000_0000_0000;   // Glider running into the row 7 col 7 corner
        patterns[1] = 64'h0000_0000_0002_0107;   // Glider running into the row 0 col 0 corner
        patterns[2] = 64'h0000_0101_0100_0000;   // Blinker on column 0
        patterns[3] = 64'h0000_0000_0000_00ff;   // Full row 0
        patterns[4] = 64'hff80_8080_8080_8080;   // Full row 7 and column 7
        patterns[5] = 64'hc381_0000_0000_81c3;   // An L in every corner
        patterns[6] = 64'h0000_4060_c000_0000;   // R-pentomino against column 7
        for (int k = 0; k < 7; k++) begin
            load_field(patterns[k]);
            for (int g = 1; g <= 8; g++) begin
                step_and_compare($sformatf("edge pattern %0d generation %0d", k, g), got);
            end
        end
    endtask

    // Seeded random fields, random run length
    task automatic test_random_fields();
        logic [fs-1:0] pattern;
        logic [fs-1:0] got;
        int            gens;
        $display("Random fields");
        for (int k = 0; k < 10; k++) begin
            pattern = {$random(seed), $random(seed)};
            gens    = 1 + ({$random(seed)} % 6);     // 1 to 6
            load_field(pattern);
            run_gens(gens);
            read_field(got);
            check(got, model, $sformatf("random field %0d after %0d generations", k, gens));
        end
    endtask

    // Hold inside an output stream and between run bursts
    task automatic test_hold();
        logic [fs-1:0] pattern;
        logic [fs-1:0] acc;
        logic [fs-1:0] got;
        $display("Hold");
        pattern = {$random(seed), $random(seed)};
        load_field(pattern);
        hold_cycles(3);
        acc = '0;
        shift_out(20, acc);
        hold_cycles(7);                        // Stream must resume at cell 20
        shift_out(fs - 20, acc);
        check(acc, pattern, "stream split by hold");
        run_gens(2);
        hold_cycles(5);
        run_gens(3);
        read_field(got);
        check(got, model, "five generations split by hold");
    endtask

    initial begin
        rst_n   = 1'b0;
        mode    = mode_hold;
        data_in = 1'b0;
        model   = '0;
        // Output low from the first reset edge on
        repeat (10) begin
            @(negedge clk);
            check({{(fs-1){1'b0}}, data_out}, '0, "data_out during reset");
        end
        rst_n = 1'b1;

        test_reset_state();
        test_load_readback();
        test_still_and_blinker();
        test_boundaries();
        test_random_fields();
        test_hold();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
rtl/conway_pkg.sv
rtl/serial_to_parallel.sv
rtl/life_cell.sv
rtl/cell_grid.sv
rtl/system_memory.sv
rtl/parallel_to_serial.sv
rtl/conway_8x8_serial.sv
bench/tb_conway.sv

/* Makefile */
SIM  := obj_dir/Vtb_conway
SRCS := $(filter-out +%,$(shell cat list.f))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): list.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_conway -f list.f

# Pass or fail is decided by the log, not by the exit status of the pipe
run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
